/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = tb_core
FILELIST = verilog.f
OBJ_DIR  = obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# fails unless the pass line shows up in the output
run: compile
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -qx "TEST PASS"

clean:
	rm -rf $(OBJ_DIR)

/* common/core_consts.svh */
// Core width and memory constants

`ifndef CORE_CONSTS_SVH
`define CORE_CONSTS_SVH

// data and address width.
`define XLEN 32

// first fetch address after reset.
`define RESET_PC 32'h8000_0000

// instruction SRAM size in words.
`define ISRAM_DEPTH 256

`endif

/* common/core_pkg.sv */
// Core shared types
`default_nettype none

package core_pkg;

  // major opcodes.
  localparam logic [6:0] OP_R = 7'b0110011;
  localparam logic [6:0] OP_I = 7'b0010011;

  // funct3 codes, shared by both formats.
  localparam logic [2:0] F3_ADD = 3'b000;
  localparam logic [2:0] F3_XOR = 3'b100;
  localparam logic [2:0] F3_OR  = 3'b110;
  localparam logic [2:0] F3_AND = 3'b111;

  // funct7 codes for r-type.
  localparam logic [6:0] F7_BASE = 7'b0000000;
  localparam logic [6:0] F7_SUB  = 7'b0100000;

  // read response code.
  localparam logic [1:0] RESP_OKAY = 2'b00;

  typedef enum logic [3:0] {
    ADD,
    SUB,
    XOR,
    OR,
    AND,
    NONE
  } alu_op_t;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm12;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  // one instruction word, two views.
  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
  } inst_u;

endpackage

`default_nettype wire

/* common/isram_rd_if.sv */
// Instruction SRAM read channel
`default_nettype none
`include "core_consts.svh"

interface isram_rd_if;
  // read address channel.
  logic [`XLEN-1:0] araddr;
  logic             arvalid;
  logic             arready;

  // read data channel.
  logic [`XLEN-1:0] rdata;
  logic [1:0]       rresp;
  logic             rvalid;
  logic             rready;

  modport master (
    output araddr, arvalid, rready,
    input  arready, rvalid, rdata, rresp
  );

  modport slave (
    input  araddr, arvalid, rready,
    output arready, rvalid, rdata, rresp
  );
endinterface

`default_nettype wire

/* common/pipe_if.sv */
// Stage to stage links
`default_nettype none
`include "core_consts.svh"

// decode to execute.
interface dec_exe_if;
  import core_pkg::*;

  logic             valid;
  alu_op_t          op;
  logic [4:0]       rd;
  logic [`XLEN-1:0] a;
  logic [`XLEN-1:0] b;
  logic [`XLEN-1:0] pc;
  logic             illegal;

  modport master (output valid, op, rd, a, b, pc, illegal);
  modport slave (input valid, op, rd, a, b, pc, illegal);
endinterface

// execute to writeback.
interface exe_wb_if;
  logic             valid;
  logic [4:0]       rd;
  logic [`XLEN-1:0] data;
  logic             we;
  logic [`XLEN-1:0] pc;
  logic             illegal;

  modport master (output valid, rd, data, we, pc, illegal);
  modport slave (input valid, rd, data, we, pc, illegal);
endinterface

`default_nettype wire

/* hdl/core_top.sv */
// RV32 core top level
`default_nettype none
`include "core_consts.svh"

module core_top (
  input  logic             clock,
  input  logic             reset,
  input  logic             run,
  input  logic             load_valid,
  input  logic [`XLEN-1:0] load_addr,
  input  logic [`XLEN-1:0] load_data,
  output logic             commit_valid,
  output logic [`XLEN-1:0] commit_pc,
  output logic [4:0]       commit_rd,
  output logic [`XLEN-1:0] commit_data,
  output logic             commit_illegal
);

  isram_rd_if rd_bus ();
  dec_exe_if  de_bus ();
  exe_wb_if   ew_bus ();

  logic [`XLEN-1:0] inst;
  logic [`XLEN-1:0] inst_pc;
  logic             inst_valid;
  logic [4:0]       rs1_addr;
  logic [4:0]       rs2_addr;
  logic [`XLEN-1:0] rs1_data;
  logic [`XLEN-1:0] rs2_data;

  isram u_isram (
    .clock      (clock),
    .reset      (reset),
    .load_valid (load_valid),
    .load_addr  (load_addr),
    .load_data  (load_data),
    .rd         (rd_bus.slave)
  );

  ifu u_ifu (
    .clock        (clock),
    .reset        (reset),
    .run          (run),
    .commit_valid (commit_valid),
    .rd           (rd_bus.master),
    .inst         (inst),
    .inst_pc      (inst_pc),
    .inst_valid   (inst_valid)
  );

  idu u_idu (
    .clock      (clock),
    .reset      (reset),
    .inst       (inst),
    .inst_pc    (inst_pc),
    .inst_valid (inst_valid),
    .rs1_addr   (rs1_addr),
    .rs2_addr   (rs2_addr),
    .rs1_data   (rs1_data),
    .rs2_data   (rs2_data),
    .de         (de_bus.master)
  );

  exu u_exu (
    .clock (clock),
    .reset (reset),
    .de    (de_bus.slave),
    .ew    (ew_bus.master)
  );

  wbu u_wbu (
    .clock          (clock),
    .reset          (reset),
    .ew             (ew_bus.slave),
    .rs1_addr       (rs1_addr),
    .rs2_addr       (rs2_addr),
    .rs1_data       (rs1_data),
    .rs2_data       (rs2_data),
    .commit_valid   (commit_valid),
    .commit_pc      (commit_pc),
    .commit_data    (commit_data),
    .commit_rd      (commit_rd),
    .commit_illegal (commit_illegal)
  );

endmodule

`default_nettype wire

/* hdl/exu.sv */
// Execute stage ALU
`default_nettype none
`include "core_consts.svh"

module exu (
  input  logic      clock,
  input  logic      reset,
  dec_exe_if.slave  de,
  exe_wb_if.master  ew
);
  import core_pkg::*;

  logic [`XLEN-1:0] result;

  always_comb begin
    case (de.op)
      ADD:     result = de.a + de.b;
      SUB:     result = de.a - de.b;
      XOR:     result = de.a ^ de.b;
      OR:      result = de.a | de.b;
      AND:     result = de.a & de.b;
      default: result = '0;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      ew.valid <= 1'b0;
    end else begin
      ew.valid <= de.valid;
    end
  end

  always_ff @(posedge clock) begin
    if (de.valid) begin
      ew.rd      <= de.rd;
      ew.data    <= result;
      // no write for illegal words or x0.
      ew.we      <= !de.illegal && (de.rd != 5'd0);
      ew.pc      <= de.pc;
      ew.illegal <= de.illegal;
    end
  end

endmodule

`default_nettype wire

/* hdl/idu.sv */
// Instruction decode stage
`default_nettype none
`include "core_consts.svh"

module idu (
  input  logic             clock,
  input  logic             reset,
  input  logic [`XLEN-1:0] inst,
  input  logic [`XLEN-1:0] inst_pc,
  input  logic             inst_valid,
  output logic [4:0]       rs1_addr,
  output logic [4:0]       rs2_addr,
  input  logic [`XLEN-1:0] rs1_data,
  input  logic [`XLEN-1:0] rs2_data,
  dec_exe_if.master        de
);
  import core_pkg::*;

  inst_u            iw;
  alu_op_t          op_d;
  logic             illegal_d;
  logic [`XLEN-1:0] b_d;

  assign iw       = inst;
  assign rs1_addr = iw.r.rs1;
  assign rs2_addr = iw.r.rs2;

  always_comb begin
    op_d      = NONE;
    illegal_d = 1'b0;
    b_d       = rs2_data;
    case (iw.r.opcode)
      OP_R: begin
        case ({iw.r.funct7, iw.r.funct3})
          {F7_BASE, F3_ADD}: op_d = ADD;
          {F7_SUB, F3_ADD}:  op_d = SUB;
          {F7_BASE, F3_XOR}: op_d = XOR;
          {F7_BASE, F3_OR}:  op_d = OR;
          {F7_BASE, F3_AND}: op_d = AND;
          default:           illegal_d = 1'b1;
        endcase
      end
      OP_I: begin
        // same bits as funct7 and rs2 in the r view.
        b_d = {{(`XLEN-12){iw.i.imm12[11]}}, iw.i.imm12};
        case (iw.i.funct3)
          F3_ADD:  op_d = ADD;
          F3_XOR:  op_d = XOR;
          F3_OR:   op_d = OR;
          F3_AND:  op_d = AND;
          default: illegal_d = 1'b1;
        endcase
      end
      default: illegal_d = 1'b1;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      de.valid <= 1'b0;
    end else begin
      de.valid <= inst_valid;
    end
  end

  always_ff @(posedge clock) begin
    if (inst_valid) begin
      de.op      <= op_d;
      de.rd      <= iw.r.rd;
      de.a       <= rs1_data;
      de.b       <= b_d;
      de.pc      <= inst_pc;
      de.illegal <= illegal_d;
    end
  end

endmodule

`default_nettype wire

/* hdl/ifu.sv */
// Instruction fetch unit
`default_nettype none
`include "core_consts.svh"

module ifu (
  input  logic             clock,
  input  logic             reset,
  input  logic             run,
  input  logic             commit_valid,
  isram_rd_if.master       rd,
  output logic [`XLEN-1:0] inst,
  output logic [`XLEN-1:0] inst_pc,
  output logic             inst_valid
);
  import core_pkg::*;

  typedef enum logic {
    S_REQ,
    S_WAIT
  } state_t;

  state_t           state;
  logic [`XLEN-1:0] pc;
  logic             arvalid_r;

  always_ff @(posedge clock) begin
    if (reset) begin
      state     <= S_REQ;
      pc        <= `RESET_PC;
      arvalid_r <= 1'b0;
    end else begin
      case (state)
        S_REQ: begin
          if (arvalid_r && rd.arready) begin
            arvalid_r <= 1'b0;
            state     <= S_WAIT;
          end else if (run) begin
            // held until the address is taken.
            arvalid_r <= 1'b1;
          end
        end
        S_WAIT: begin
          if (commit_valid) begin
            pc        <= pc + `XLEN'(4);
            arvalid_r <= run;
            state     <= S_REQ;
          end
        end
        default: state <= S_REQ;
      endcase
    end
  end

  assign rd.araddr  = pc;
  assign rd.arvalid = arvalid_r;
  assign rd.rready  = (state == S_WAIT);

  // a bad response turns into an all-zero word, which decodes as illegal.
  assign inst       = (rd.rresp == RESP_OKAY) ? rd.rdata : '0;
  assign inst_pc    = pc;
  assign inst_valid = rd.rvalid && rd.rready;

endmodule

`default_nettype wire

/* hdl/wbu.sv */
// Writeback and register file
`default_nettype none
`include "core_consts.svh"

module wbu (
  input  logic             clock,
  input  logic             reset,
  exe_wb_if.slave          ew,
  input  logic [4:0]       rs1_addr,
  input  logic [4:0]       rs2_addr,
  output logic [`XLEN-1:0] rs1_data,
  output logic [`XLEN-1:0] rs2_data,
  output logic             commit_valid,
  output logic [`XLEN-1:0] commit_pc,
  output logic [`XLEN-1:0] commit_data,
  output logic [4:0]       commit_rd,
  output logic             commit_illegal
);

  // x1 to x31 only.
  logic [`XLEN-1:0] regs [1:31];

  always_ff @(posedge clock) begin
    if (ew.valid && ew.we) begin
      regs[ew.rd] <= ew.data;
    end
  end

  assign rs1_data = (rs1_addr == 5'd0) ? '0 : regs[rs1_addr];
  assign rs2_data = (rs2_addr == 5'd0) ? '0 : regs[rs2_addr];

  // ##################################################
  // commit report
  // ##################################################

  always_ff @(posedge clock) begin
    if (reset) begin
      commit_valid <= 1'b0;
    end else begin
      commit_valid <= ew.valid;
    end
  end

  always_ff @(posedge clock) begin
    if (ew.valid) begin
      commit_pc      <= ew.pc;
      commit_data    <= ew.data;
      commit_rd      <= ew.rd;
      commit_illegal <= ew.illegal;
    end
  end

endmodule

`default_nettype wire

/* isram/isram.sv */
// Instruction SRAM model
`default_nettype none
`include "core_consts.svh"

module isram (
  input  logic             clock,
  input  logic             reset,
  input  logic             load_valid,
  input  logic [`XLEN-1:0] load_addr,
  input  logic [`XLEN-1:0] load_data,
  isram_rd_if.slave        rd
);
  import core_pkg::*;

  localparam int AW = $clog2(`ISRAM_DEPTH);

  typedef enum logic [2:0] {
    IDLE,
    WAIT_ARVALID,
    SHAKED_AR,
    WAIT_RREADY,
    SHAKED_R
  } state_t;

  state_t           state;
  state_t           next;
  logic             arready_r;
  logic             rvalid_r;
  logic [`XLEN-1:0] rdata_r;
  logic [`XLEN-1:0] mem [`ISRAM_DEPTH];

  // ##################################################
  // read FSM
  // ##################################################

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= IDLE;
    end else begin
      state <= next;
    end
  end

  always_comb begin
    next = IDLE;
    case (state)
      IDLE, SHAKED_R: begin
        if (!arready_r) next = IDLE;
        else if (!rd.arvalid) next = WAIT_ARVALID;
        else next = SHAKED_AR;
      end
      WAIT_ARVALID: next = rd.arvalid ? SHAKED_AR : WAIT_ARVALID;
      SHAKED_AR:    next = rd.rready ? SHAKED_R : WAIT_RREADY;
      WAIT_RREADY:  next = rd.rready ? SHAKED_R : WAIT_RREADY;
      default:      next = IDLE;
    endcase
  end

  // no new address until the data is taken.
  always_ff @(posedge clock) begin
    if (reset) begin
      arready_r <= 1'b0;
      rvalid_r  <= 1'b0;
    end else begin
      arready_r <= (next == IDLE) || (next == WAIT_ARVALID) || (next == SHAKED_R);
      rvalid_r  <= (next == SHAKED_AR) || (next == WAIT_RREADY);
    end
  end

  // ##################################################
  // word array
  // ##################################################

  always_ff @(posedge clock) begin
    if (load_valid) begin
      mem[load_addr[AW+1:2]] <= load_data;
    end
  end

  // word captured on the address handshake.
  always_ff @(posedge clock) begin
    if (next == SHAKED_AR) begin
      rdata_r <= mem[rd.araddr[AW+1:2]];
    end
  end

  assign rd.arready = arready_r;
  assign rd.rvalid  = rvalid_r;
  assign rd.rdata   = rdata_r;
  assign rd.rresp   = RESP_OKAY;

endmodule

`default_nettype wire

/* testbench/core_model.svh */
// Reference ISA model and program generator

`ifndef CORE_MODEL_SVH
`define CORE_MODEL_SVH

// architectural registers, x0 included.
logic [31:0] model_regs [32];

function automatic void clear_model();
  for (int r = 0; r < 32; r++) begin
    model_regs[r] = '0;
  end
endfunction

// one random program word for slot idx.
function automatic logic [31:0] make_word(input int idx);
  logic [4:0]  rd;
  logic [4:0]  rs1;
  logic [4:0]  rs2;
  logic [11:0] imm;
  logic [31:0] word;
  int          pick;
  int          kind;
  rd   = 5'($random(seed));
  rs1  = 5'($random(seed));
  rs2  = 5'($random(seed));
  imm  = 12'($random(seed));
  pick = {$random(seed)} % 100;
  kind = {$random(seed)} % 5;
  if ({$random(seed)} % 8 == 0) begin
    rd = 5'd0;
  end
  if (idx < 31) begin
    // addi x(idx+1), x0, imm so every register holds a known value.
    word = {imm, 5'd0, 3'b000, 5'(idx + 1), 7'b0010011};
  end else if (pick < 45) begin
    case (kind)
      0:       word = {7'b0000000, rs2, rs1, 3'b000, rd, 7'b0110011};
      1:       word = {7'b0100000, rs2, rs1, 3'b000, rd, 7'b0110011};
      2:       word = {7'b0000000, rs2, rs1, 3'b100, rd, 7'b0110011};
      3:       word = {7'b0000000, rs2, rs1, 3'b110, rd, 7'b0110011};
      default: word = {7'b0000000, rs2, rs1, 3'b111, rd, 7'b0110011};
    endcase
  end else if (pick < 90) begin
    case (kind % 4)
      0:       word = {imm, rs1, 3'b000, rd, 7'b0010011};
      1:       word = {imm, rs1, 3'b100, rd, 7'b0010011};
      2:       word = {imm, rs1, 3'b110, rd, 7'b0010011};
      default: word = {imm, rs1, 3'b111, rd, 7'b0010011};
    endcase
  end else begin
    word = $random(seed);
    // move off the two supported opcodes.
    if (word[6:0] == 7'b0110011 || word[6:0] == 7'b0010011) begin
      word[6] = ~word[6];
    end
  end
  return word;
endfunction

// architectural effect of one word.
function automatic void execute_word(input logic [31:0] word, output logic [31:0] result,
                                     output logic illegal);
  logic [31:0] a;
  logic [31:0] b;
  a       = model_regs[word[19:15]];
  b       = model_regs[word[24:20]];
  result  = '0;
  illegal = 1'b0;
  if (word[6:0] == 7'b0110011) begin
    case ({word[31:25], word[14:12]})
      10'b0000000_000: result = a + b;
      10'b0100000_000: result = a - b;
      10'b0000000_100: result = a ^ b;
      10'b0000000_110: result = a | b;
      10'b0000000_111: result = a & b;
      default:         illegal = 1'b1;
    endcase
  end else if (word[6:0] == 7'b0010011) begin
    b = {{20{word[31]}}, word[31:20]};
    case (word[14:12])
      3'b000:  result = a + b;
      3'b100:  result = a ^ b;
      3'b110:  result = a | b;
      3'b111:  result = a & b;
      default: illegal = 1'b1;
    endcase
  end else begin
    illegal = 1'b1;
  end
  if (!illegal && word[11:7] != 5'd0) begin
    model_regs[word[11:7]] = result;
  end
endfunction

`endif

/* testbench/tb_core.sv */
// Core testbench
`default_nettype none
`include "core_consts.svh"

module tb_core;

  localparam int NUM_WORDS   = 200;
  localparam int CYCLE_LIMIT = NUM_WORDS * 12 + 100;

  logic             clock = 1'b0;
  logic             reset;
  logic             run;
  logic             load_valid;
  logic [`XLEN-1:0] load_addr;
  logic [`XLEN-1:0] load_data;
  logic             commit_valid;
  logic [`XLEN-1:0] commit_pc;
  logic [4:0]       commit_rd;
  logic [`XLEN-1:0] commit_data;
  logic             commit_illegal;

  integer      seed           = 31675;
  int          commit_count   = 0;
  int          check_count    = 0;
  int          mismatch_count = 0;
  int          other_count    = 0;
  int          cycle_count    = 0;
  logic [31:0] program_words [NUM_WORDS];

  `include "core_model.svh"

  core_top u_core_top (
    .clock          (clock),
    .reset          (reset),
    .run            (run),
    .load_valid     (load_valid),
    .load_addr      (load_addr),
    .load_data      (load_data),
    .commit_valid   (commit_valid),
    .commit_pc      (commit_pc),
    .commit_rd      (commit_rd),
    .commit_data    (commit_data),
    .commit_illegal (commit_illegal)
  );

  always #4 clock = ~clock;

  // ##################################################
  // checks
  // ##################################################

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    check_count++;
    assert (actual === expected) else begin
      mismatch_count++;
      $display("mismatch %s at commit %0d: expected %h actual %h",
               name, commit_count, expected, actual);
    end
  endtask

  task automatic check_commit();
    logic [31:0] word;
    logic [31:0] exp_data;
    logic        exp_illegal;
    string       name;
    if (commit_count >= NUM_WORDS) begin
      other_count++;
      $display("unexpected commit after the last word, pc %h", commit_pc);
    end else begin
      word = program_words[commit_count];
      execute_word(word, exp_data, exp_illegal);
      check_value("commit pc", `RESET_PC + 32'(4 * commit_count), commit_pc);
      check_value("commit illegal", 32'(exp_illegal), 32'(commit_illegal));
      if (!exp_illegal) begin
        if (word[11:7] == 5'd0) name = "x0 write data";
        else if (word[6:0] == 7'b0110011) name = "r-type data";
        else name = "i-type data";
        check_value("commit rd", 32'(word[11:7]), 32'(commit_rd));
        check_value(name, exp_data, commit_data);
      end
      commit_count++;
    end
  endtask

  task automatic finish_run();
    $display("commits %0d of %0d, checks %0d, mismatches %0d, other errors %0d",
             commit_count, NUM_WORDS, check_count, mismatch_count, other_count);
    if (mismatch_count == 0 && other_count == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  endtask

  // outputs are settled half a cycle after the edge.
  always @(negedge clock) begin
    if (!reset && commit_valid) begin
      check_commit();
    end
  end

  always @(posedge clock) begin
    if (run) begin
      cycle_count++;
    end
    if (cycle_count >= CYCLE_LIMIT) begin
      other_count++;
      $display("timeout: only %0d of %0d words committed in %0d cycles",
               commit_count, NUM_WORDS, cycle_count);
      finish_run();
    end
  end

  // ##################################################
  // stimulus
  // ##################################################

  initial begin
    reset      = 1'b1;
    run        = 1'b0;
    load_valid = 1'b0;
    load_addr  = '0;
    load_data  = '0;
    clear_model();
    for (int i = 0; i < NUM_WORDS; i++) begin
      program_words[i] = make_word(i);
    end
    repeat (3) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;

    // program goes in before the core runs.
    for (int i = 0; i < NUM_WORDS; i++) begin
      @(negedge clock);
      load_valid = 1'b1;
      load_addr  = `RESET_PC + 32'(4 * i);
      load_data  = program_words[i];
    end
    @(negedge clock);
    load_valid = 1'b0;
    run        = 1'b1;

    wait (commit_count == NUM_WORDS);
    // no further fetch, so no commit may follow the last word.
    run = 1'b0;
    repeat (8) @(posedge clock);
    finish_run();
  end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+common
+incdir+testbench
common/core_pkg.sv
common/isram_rd_if.sv
common/pipe_if.sv
isram/isram.sv
hdl/ifu.sv
hdl/idu.sv
hdl/exu.sv
hdl/wbu.sv
hdl/core_top.sv
testbench/tb_core.sv
